//--- vlog.f
hdl/mmu_pkg.sv
hdl/tlb.sv
hdl/ptw.sv
hdl/mmu_top.sv
verif/pt_mem_model.sv
verif/mmu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module mmu_tb -Mdir obj_dir
./obj_dir/Vmmu_tb > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

//--- verif/mmu_tb.sv
// Directed MMU testbench; page tables follow Sv39 rules and each mapping owns its top VPN segment
`timescale 1ns/1ns

module mmu_tb
    import mmu_pkg::*;
();

    localparam int   resp_timeout = 400;
    localparam ppn_t root_ppn     = 44'h100;

    logic   clk;
    logic   rst_n;
    priv_t  priv;
    logic   vm_enable;
    logic   flush;
    ppn_t   satp_ppn;
    logic   itlb_req_valid;
    vpn_t   itlb_req_vpn;
    logic   itlb_ready;
    logic   itlb_resp_valid;
    ppn_t   itlb_resp_ppn;
    logic   itlb_resp_fault;
    logic   dtlb_req_valid;
    vpn_t   dtlb_req_vpn;
    logic   dtlb_ready;
    logic   dtlb_resp_valid;
    ppn_t   dtlb_resp_ppn;
    logic   dtlb_resp_fault;
    logic   mem_req_valid;
    paddr_t mem_req_addr;
    logic   mem_ready;
    logic   mem_resp_valid;
    pte_t   mem_resp_data;
    logic   mem_backpressure;
    int     read_count;

    int     errors;
    int     checks;
    ppn_t   next_table;

    mmu_top dut_i (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .priv_i            (priv),
        .vm_enable_i       (vm_enable),
        .flush_i           (flush),
        .satp_ppn_i        (satp_ppn),
        .itlb_req_valid_i  (itlb_req_valid),
        .itlb_req_vpn_i    (itlb_req_vpn),
        .itlb_ready_o      (itlb_ready),
        .itlb_resp_valid_o (itlb_resp_valid),
        .itlb_resp_ppn_o   (itlb_resp_ppn),
        .itlb_resp_fault_o (itlb_resp_fault),
        .dtlb_req_valid_i  (dtlb_req_valid),
        .dtlb_req_vpn_i    (dtlb_req_vpn),
        .dtlb_ready_o      (dtlb_ready),
        .dtlb_resp_valid_o (dtlb_resp_valid),
        .dtlb_resp_ppn_o   (dtlb_resp_ppn),
        .dtlb_resp_fault_o (dtlb_resp_fault),
        .mem_req_valid_o   (mem_req_valid),
        .mem_req_addr_o    (mem_req_addr),
        .mem_ready_i       (mem_ready),
        .mem_resp_valid_i  (mem_resp_valid),
        .mem_resp_data_i   (mem_resp_data)
    );

    pt_mem_model mem_u (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .backpressure_i (mem_backpressure),
        .req_valid_i    (mem_req_valid),
        .req_addr_i     (mem_req_addr),
        .ready_o        (mem_ready),
        .resp_valid_o   (mem_resp_valid),
        .resp_data_o    (mem_resp_data),
        .read_count_o   (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_ppn(input string name, input ppn_t got, input ppn_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // Page table construction
    // ------------------------------------------------------------------
    function automatic pte_t make_pte(input ppn_t ppn, input logic r, input logic x,
                                      input logic u);
        pte_t p;
        p = '0;
        p[pte_ppn_lsb +: ppn_w] = ppn;
        p[pte_v_bit] = 1'b1;
        p[pte_r_bit] = r;
        p[pte_x_bit] = x;
        p[pte_u_bit] = u;
        return p;
    endfunction

    // Table base times page size plus segment times 8
    function automatic paddr_t pte_addr(input ppn_t base, input vpn_t vpn, input int level);
        vpn_t                 shifted;
        logic [vpn_seg_w-1:0] seg;
        shifted = vpn >> (level * vpn_seg_w);
        seg = shifted[vpn_seg_w-1:0];
        return (paddr_t'(base) << page_off_w) + (paddr_t'(seg) << 3);
    endfunction

    task automatic map_page(input vpn_t vpn, input int leaf_level, input ppn_t leaf_ppn,
                            input logic r, input logic x, input logic u);
        ppn_t base;
        base = root_ppn;
        for (int lvl = levels - 1; lvl > leaf_level; lvl--) begin
            mem_u.write_pte(pte_addr(base, vpn, lvl), make_pte(next_table, 1'b0, 1'b0, 1'b0));
            base = next_table;
            next_table = next_table + 1;
        end
        mem_u.write_pte(pte_addr(base, vpn, leaf_level), make_pte(leaf_ppn, r, x, u));
    endtask

    // ------------------------------------------------------------------
    // Requests are always driven 1 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic translate(input logic instr, input vpn_t vpn, output ppn_t ppn,
                             output logic fault, output int latency, output int reads);
        int start_reads;
        int n;
        start_reads = read_count;
        n = 0;
        ppn = '0;
        fault = 1'bx;
        latency = 0;
        reads = 0;
        while (!(instr ? itlb_ready : dtlb_ready)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > resp_timeout) begin
                errors++;
                $display("TLB never became ready for vpn %h at %0t", vpn, $time);
                return;
            end
        end
        if (instr) begin
            itlb_req_valid = 1'b1;
            itlb_req_vpn   = vpn;
        end else begin
            dtlb_req_valid = 1'b1;
            dtlb_req_vpn   = vpn;
        end
        @(posedge clk);
        #1;
        itlb_req_valid = 1'b0;
        dtlb_req_valid = 1'b0;
        latency = 1;
        while (!(instr ? itlb_resp_valid : dtlb_resp_valid)) begin
            @(posedge clk);
            #1;
            latency++;
            if (latency > resp_timeout) begin
                errors++;
                $display("No TLB response for vpn %h at %0t", vpn, $time);
                return;
            end
        end
        ppn   = instr ? itlb_resp_ppn : dtlb_resp_ppn;
        fault = instr ? itlb_resp_fault : dtlb_resp_fault;
        reads = read_count - start_reads;
    endtask

    // Expected latency of 0 means any latency
    task automatic verify_mapping(input logic instr, input vpn_t vpn, input ppn_t exp_ppn,
                                  input int exp_reads, input int exp_latency);
        ppn_t ppn;
        logic fault;
        int   latency;
        int   reads;
        translate(instr, vpn, ppn, fault, latency, reads);
        check_ppn(instr ? "itlb_resp_ppn_o" : "dtlb_resp_ppn_o", ppn, exp_ppn);
        check_bit(instr ? "itlb_resp_fault_o" : "dtlb_resp_fault_o", fault, 1'b0);
        check_count("memory reads", reads, exp_reads);
        if (exp_latency != 0) begin
            check_count("response latency", latency, exp_latency);
        end
    endtask

    task automatic confirm_fault(input logic instr, input vpn_t vpn, input int exp_reads);
        ppn_t ppn;
        logic fault;
        int   latency;
        int   reads;
        translate(instr, vpn, ppn, fault, latency, reads);
        check_bit(instr ? "itlb_resp_fault_o" : "dtlb_resp_fault_o", fault, 1'b1);
        check_count("memory reads", reads, exp_reads);
    endtask

    task automatic pulse_flush();
        int n;
        n = 0;
        while (!(itlb_ready && dtlb_ready)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > resp_timeout) begin
                errors++;
                $display("TLBs never became ready for the flush at %0t", $time);
                return;
            end
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_bare_mode();
        vpn_t v;
        vm_enable = 1'b0;
        v = 27'h7abcdef;
        verify_mapping(1'b1, v, ppn_t'(v), 0, 1);
        v = 27'h0123456;
        verify_mapping(1'b0, v, ppn_t'(v), 0, 1);
        vm_enable = 1'b1;
    endtask

    task automatic test_miss_then_hit();
        vpn_t v;
        v = {9'd1, 9'd5, 9'd7};
        map_page(v, 0, 44'h12345, 1'b1, 1'b0, 1'b0);
        verify_mapping(1'b0, v, 44'h12345, 3, 0);
        verify_mapping(1'b0, v, 44'h12345, 0, 1);
    endtask

    task automatic test_superpage();
        vpn_t v;
        ppn_t exp;
        v = {9'd2, 9'd33, 9'd101};
        map_page(v, 1, 44'h0abcdff, 1'b1, 1'b0, 1'b0);
        exp = 44'h0abcdff;
        exp[vpn_seg_w-1:0] = v[vpn_seg_w-1:0];
        verify_mapping(1'b0, v, exp, 2, 0);
    endtask

    task automatic test_faults();
        vpn_t v_inv;
        vpn_t v_nox;
        vpn_t v_nou;
        vpn_t v_u;
        // Top segment 3 left unmapped so the root entry reads as invalid
        v_inv = {9'd3, 9'd1, 9'd1};
        v_nox = {9'd4, 9'd2, 9'd2};
        v_nou = {9'd5, 9'd3, 9'd3};
        v_u   = {9'd6, 9'd4, 9'd4};
        map_page(v_nox, 0, 44'h400, 1'b1, 1'b0, 1'b0);
        map_page(v_nou, 0, 44'h500, 1'b1, 1'b0, 1'b0);
        map_page(v_u, 0, 44'h600, 1'b1, 1'b0, 1'b1);
        for (int i = 0; i < 2; i++) begin
            confirm_fault(1'b0, v_inv, 1);
            confirm_fault(1'b1, v_nox, 3);
            priv = priv_user;
            confirm_fault(1'b0, v_nou, 3);
            priv = priv_supervisor;
            confirm_fault(1'b0, v_u, 3);
        end
    endtask

    task automatic test_flush_refill();
        vpn_t v;
        v = {9'd7, 9'd9, 9'd11};
        map_page(v, 0, 44'h700, 1'b1, 1'b0, 1'b0);
        verify_mapping(1'b0, v, 44'h700, 3, 0);
        verify_mapping(1'b0, v, 44'h700, 0, 1);
        pulse_flush();
        verify_mapping(1'b0, v, 44'h700, 3, 0);

        // Five fills into four slots push out the oldest
        pulse_flush();
        for (int i = 0; i < 5; i++) begin
            v = {9'(8 + i), 9'd0, 9'(i)};
            map_page(v, 0, 44'h300 + ppn_t'(i), 1'b0, 1'b1, 1'b0);
            verify_mapping(1'b1, v, 44'h300 + ppn_t'(i), 3, 0);
        end
        verify_mapping(1'b1, {9'd12, 9'd0, 9'd4}, 44'h304, 0, 1);
        // The three fills after the first one stay resident
        for (int i = 1; i < 4; i++) begin
            verify_mapping(1'b1, {9'(8 + i), 9'd0, 9'(i)}, 44'h300 + ppn_t'(i), 0, 1);
        end
        verify_mapping(1'b1, {9'd8, 9'd0, 9'd0}, 44'h300, 3, 0);
    endtask

    task automatic test_concurrent_misses();
        vpn_t v_i;
        vpn_t v_d;
        int   start_reads;
        int   cyc;
        int   i_cyc;
        int   d_cyc;
        v_i = {9'd13, 9'd21, 9'd31};
        v_d = {9'd14, 9'd22, 9'd32};
        map_page(v_i, 0, 44'h777, 1'b0, 1'b1, 1'b0);
        map_page(v_d, 0, 44'h888, 1'b1, 1'b0, 1'b0);
        mem_backpressure = 1'b1;
        pulse_flush();
        start_reads = read_count;
        itlb_req_valid = 1'b1;
        itlb_req_vpn   = v_i;
        dtlb_req_valid = 1'b1;
        dtlb_req_vpn   = v_d;
        @(posedge clk);
        #1;
        itlb_req_valid = 1'b0;
        dtlb_req_valid = 1'b0;
        cyc = 1;
        i_cyc = 0;
        d_cyc = 0;
        while (i_cyc == 0 || d_cyc == 0) begin
            if (itlb_resp_valid && i_cyc == 0) begin
                i_cyc = cyc;
                check_ppn("itlb_resp_ppn_o", itlb_resp_ppn, 44'h777);
                check_bit("itlb_resp_fault_o", itlb_resp_fault, 1'b0);
            end
            if (dtlb_resp_valid && d_cyc == 0) begin
                d_cyc = cyc;
                check_ppn("dtlb_resp_ppn_o", dtlb_resp_ppn, 44'h888);
                check_bit("dtlb_resp_fault_o", dtlb_resp_fault, 1'b0);
            end
            if (cyc > resp_timeout) begin
                errors++;
                $display("Concurrent misses did not both complete by %0t", $time);
                break;
            end
            @(posedge clk);
            #1;
            cyc++;
        end
        check_bit("dtlb response before itlb", d_cyc < i_cyc, 1'b1);
        check_count("memory reads", read_count - start_reads, 6);
        mem_backpressure = 1'b0;
    endtask

    initial begin
        errors           = 0;
        checks           = 0;
        next_table       = 44'h200;
        rst_n            = 1'b0;
        priv             = priv_supervisor;
        vm_enable        = 1'b1;
        flush            = 1'b0;
        satp_ppn         = root_ppn;
        itlb_req_valid   = 1'b0;
        itlb_req_vpn     = '0;
        dtlb_req_valid   = 1'b0;
        dtlb_req_vpn     = '0;
        mem_backpressure = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("itlb_ready_o", itlb_ready, 1'b1);
        check_bit("dtlb_ready_o", dtlb_ready, 1'b1);
        check_bit("itlb_resp_valid_o", itlb_resp_valid, 1'b0);
        check_bit("dtlb_resp_valid_o", dtlb_resp_valid, 1'b0);
        check_bit("mem_req_valid_o", mem_req_valid, 1'b0);

        test_bare_mode();
        test_miss_then_hit();
        test_superpage();
        test_faults();
        test_flush_refill();
        test_concurrent_misses();

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/pt_mem_model.sv
// PTE memory for the testbench; absent addresses read as zero, one read at a time, LFSR back-pressure
`timescale 1ns/1ns

module pt_mem_model
    import mmu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    backpressure_i,
    input  logic    req_valid_i,
    input  paddr_t  req_addr_i,
    output logic    ready_o,
    output logic    resp_valid_o,
    output pte_t    resp_data_o,
    output int      read_count_o
);

    localparam logic [31:0] lfsr_seed = 32'hf52c321e;

    pte_t           pte_mem [paddr_t];
    logic [31:0]    lfsr_q;
    logic           accept_q;
    logic           busy_q;
    paddr_t         addr_q;
    int             wait_q;
    logic           bp;
    logic           rst_n;

    task automatic write_pte(input paddr_t addr, input pte_t data);
        pte_mem[addr] = data;
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic take_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = b ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        return b;
    endfunction

    initial begin
        lfsr_q       = lfsr_seed;
        ready_o      = 1'b1;
        resp_valid_o = 1'b0;
        resp_data_o  = '0;
        read_count_o = 0;
        accept_q     = 1'b0;
        busy_q       = 1'b0;
        addr_q       = '0;
        wait_q       = 0;
        forever begin
            @(posedge clk_i);
            bp    = backpressure_i;
            rst_n = rst_n_i;
            #1;
            resp_valid_o = 1'b0;
            if (!rst_n) begin
                accept_q = 1'b0;
                busy_q   = 1'b0;
                ready_o  = 1'b1;
            end else begin
                // Read taken at the edge just passed
                if (accept_q) begin
                    busy_q = 1'b1;
                    read_count_o++;
                    wait_q = 0;
                    if (take_bit()) begin
                        wait_q += 2;
                    end
                    if (take_bit()) begin
                        wait_q += 1;
                    end
                end
                if (busy_q) begin
                    if (wait_q == 0) begin
                        resp_valid_o = 1'b1;
                        if (pte_mem.exists(addr_q)) begin
                            resp_data_o = pte_mem[addr_q];
                        end else begin
                            resp_data_o = '0;
                        end
                        busy_q = 1'b0;
                    end else begin
                        wait_q--;
                    end
                end
                ready_o  = bp ? take_bit() : 1'b1;
                accept_q = req_valid_i && ready_o;
                if (accept_q) begin
                    addr_q = req_addr_i;
                end
            end
        end
    end

endmodule

//--- hdl/mmu_top.sv
// Instruction and data TLB sharing one walker and one PTE read port; adds no cycles of its own
`timescale 1ns/1ns

module mmu_top
    import mmu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    // Translation control
    input  priv_t   priv_i,
    input  logic    vm_enable_i,
    input  logic    flush_i,
    input  ppn_t    satp_ppn_i,

    // Instruction side
    input  logic    itlb_req_valid_i,
    input  vpn_t    itlb_req_vpn_i,
    output logic    itlb_ready_o,
    output logic    itlb_resp_valid_o,
    output ppn_t    itlb_resp_ppn_o,
    output logic    itlb_resp_fault_o,

    // Data side
    input  logic    dtlb_req_valid_i,
    input  vpn_t    dtlb_req_vpn_i,
    output logic    dtlb_ready_o,
    output logic    dtlb_resp_valid_o,
    output ppn_t    dtlb_resp_ppn_o,
    output logic    dtlb_resp_fault_o,

    // PTE read port
    output logic    mem_req_valid_o,
    output paddr_t  mem_req_addr_o,
    input  logic    mem_ready_i,
    input  logic    mem_resp_valid_i,
    input  pte_t    mem_resp_data_i
);

    // TLB to walker
    logic   itlb_walk_valid;
    vpn_t   itlb_walk_vpn;
    logic   dtlb_walk_valid;
    vpn_t   dtlb_walk_vpn;

    // Walker to both TLBs
    logic   itlb_done;
    logic   dtlb_done;
    ppn_t   done_ppn;
    logic   done_leaf_ok;
    logic   done_x;
    logic   done_r;
    logic   done_u;

    tlb #(
        .instr_side(1'b1)
    ) itlb_u (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_valid_i    (itlb_req_valid_i),
        .req_vpn_i      (itlb_req_vpn_i),
        .ready_o        (itlb_ready_o),
        .resp_valid_o   (itlb_resp_valid_o),
        .resp_ppn_o     (itlb_resp_ppn_o),
        .resp_fault_o   (itlb_resp_fault_o),
        .priv_i         (priv_i),
        .vm_enable_i    (vm_enable_i),
        .flush_i        (flush_i),
        .walk_valid_o   (itlb_walk_valid),
        .walk_vpn_o     (itlb_walk_vpn),
        .walk_done_i    (itlb_done),
        .walk_ppn_i     (done_ppn),
        .walk_leaf_ok_i (done_leaf_ok),
        .walk_x_i       (done_x),
        .walk_r_i       (done_r),
        .walk_u_i       (done_u)
    );

    tlb #(
        .instr_side(1'b0)
    ) dtlb_u (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_valid_i    (dtlb_req_valid_i),
        .req_vpn_i      (dtlb_req_vpn_i),
        .ready_o        (dtlb_ready_o),
        .resp_valid_o   (dtlb_resp_valid_o),
        .resp_ppn_o     (dtlb_resp_ppn_o),
        .resp_fault_o   (dtlb_resp_fault_o),
        .priv_i         (priv_i),
        .vm_enable_i    (vm_enable_i),
        .flush_i        (flush_i),
        .walk_valid_o   (dtlb_walk_valid),
        .walk_vpn_o     (dtlb_walk_vpn),
        .walk_done_i    (dtlb_done),
        .walk_ppn_i     (done_ppn),
        .walk_leaf_ok_i (done_leaf_ok),
        .walk_x_i       (done_x),
        .walk_r_i       (done_r),
        .walk_u_i       (done_u)
    );

    ptw ptw_u (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .itlb_walk_valid_i (itlb_walk_valid),
        .itlb_walk_vpn_i   (itlb_walk_vpn),
        .dtlb_walk_valid_i (dtlb_walk_valid),
        .dtlb_walk_vpn_i   (dtlb_walk_vpn),
        .satp_ppn_i        (satp_ppn_i),
        .itlb_done_o       (itlb_done),
        .dtlb_done_o       (dtlb_done),
        .done_ppn_o        (done_ppn),
        .done_leaf_ok_o    (done_leaf_ok),
        .done_x_o          (done_x),
        .done_r_o          (done_r),
        .done_u_o          (done_u),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_ready_i       (mem_ready_i),
        .mem_resp_valid_i  (mem_resp_valid_i),
        .mem_resp_data_i   (mem_resp_data_i)
    );

endmodule

//--- hdl/ptw.sv
// Page table walker for two TLBs; one walk and one memory read at a time, data side wins, no A/D update
`timescale 1ns/1ns

module ptw
    import mmu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    // Walk requests, held levels
    input  logic    itlb_walk_valid_i,
    input  vpn_t    itlb_walk_vpn_i,
    input  logic    dtlb_walk_valid_i,
    input  vpn_t    dtlb_walk_vpn_i,

    // Root table
    input  ppn_t    satp_ppn_i,

    // Walk results, done is a one-cycle pulse
    output logic    itlb_done_o,
    output logic    dtlb_done_o,
    output ppn_t    done_ppn_o,
    output logic    done_leaf_ok_o,
    output logic    done_x_o,
    output logic    done_r_o,
    output logic    done_u_o,

    // Memory read port
    output logic    mem_req_valid_o,
    output paddr_t  mem_req_addr_o,
    input  logic    mem_ready_i,
    input  logic    mem_resp_valid_i,
    input  pte_t    mem_resp_data_i
);

    ptw_state_t state_q;
    logic       sel_dtlb_q;
    level_t     level_q;

    // Walk payload
    vpn_t   vpn_q;
    ppn_t   base_q;
    ppn_t   done_ppn_q;
    logic   done_ok_q;
    logic   done_x_q;
    logic   done_r_q;
    logic   done_u_q;

    // Entry decode
    logic   pte_v;
    logic   pte_r;
    logic   pte_w;
    logic   pte_x;
    logic   pte_u;
    ppn_t   pte_ppn;
    logic   pte_bad;
    logic   pte_table;
    logic   walk_descend;
    logic   walk_fault;
    ppn_t   leaf_ppn;
    logic [vpn_seg_w-1:0] vpn_seg;

    // ------------------------------------------------------------------
    // PTE decode
    // ------------------------------------------------------------------
    assign pte_v   = mem_resp_data_i[pte_v_bit];
    assign pte_r   = mem_resp_data_i[pte_r_bit];
    assign pte_w   = mem_resp_data_i[pte_w_bit];
    assign pte_x   = mem_resp_data_i[pte_x_bit];
    assign pte_u   = mem_resp_data_i[pte_u_bit];
    assign pte_ppn = mem_resp_data_i[pte_ppn_lsb +: ppn_w];

    // Reserved W without R counts as invalid
    assign pte_bad   = !pte_v || (pte_w && !pte_r);
    assign pte_table = !pte_r && !pte_x;

    // Pointer at level 0 has nowhere to go
    assign walk_descend = !pte_bad && pte_table && (level_q != '0);
    assign walk_fault   = pte_bad || (pte_table && level_q == '0);

    // Superpage leaf takes the lower segments from the VPN
    always_comb begin
        leaf_ppn = pte_ppn;
        for (int i = 0; i < levels; i++) begin
            if (i < int'(level_q)) begin
                leaf_ppn[i*vpn_seg_w +: vpn_seg_w] = vpn_q[i*vpn_seg_w +: vpn_seg_w];
            end
        end
    end

    // ------------------------------------------------------------------
    // Entry address
    // ------------------------------------------------------------------
    // base * page size + segment * 8
    assign vpn_seg        = vpn_q[level_q*vpn_seg_w +: vpn_seg_w];
    assign mem_req_addr_o = {base_q, vpn_seg, {(page_off_w - vpn_seg_w){1'b0}}};
    assign mem_req_valid_o = (state_q == ptw_mem_req);

    // ------------------------------------------------------------------
    // Walk FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= ptw_idle;
            sel_dtlb_q <= 1'b0;
            level_q    <= '0;
        end else begin
            case (state_q)
                ptw_idle: begin
                    if (dtlb_walk_valid_i || itlb_walk_valid_i) begin
                        sel_dtlb_q <= dtlb_walk_valid_i;
                        level_q    <= level_t'(levels - 1);
                        state_q    <= ptw_mem_req;
                    end
                end
                ptw_mem_req: begin
                    if (mem_ready_i) begin
                        state_q <= ptw_mem_wait;
                    end
                end
                ptw_mem_wait: begin
                    if (mem_resp_valid_i) begin
                        if (walk_descend) begin
                            level_q <= level_q - 1'b1;
                            state_q <= ptw_mem_req;
                        end else begin
                            state_q <= ptw_done;
                        end
                    end
                end
                default: begin
                    state_q <= ptw_idle;
                end
            endcase
        end
    end

    // Walk payload, loaded at start and on each response
    always_ff @(posedge clk_i) begin
        if (state_q == ptw_idle) begin
            vpn_q  <= dtlb_walk_valid_i ? dtlb_walk_vpn_i : itlb_walk_vpn_i;
            base_q <= satp_ppn_i;
        end
        if (state_q == ptw_mem_wait && mem_resp_valid_i) begin
            if (walk_descend) begin
                base_q <= pte_ppn;
            end else begin
                done_ppn_q <= leaf_ppn;
                done_ok_q  <= !walk_fault;
                done_x_q   <= pte_x;
                done_r_q   <= pte_r;
                done_u_q   <= pte_u;
            end
        end
    end

    // Done pulse goes to the owner only
    assign dtlb_done_o    = (state_q == ptw_done) && sel_dtlb_q;
    assign itlb_done_o    = (state_q == ptw_done) && !sel_dtlb_q;
    assign done_ppn_o     = done_ppn_q;
    assign done_leaf_ok_o = done_ok_q;
    assign done_x_o       = done_x_q;
    assign done_r_o       = done_r_q;
    assign done_u_o       = done_u_q;

endmodule

//--- hdl/tlb.sv
// Fully associative TLB; data side checks reads only, faulting walks are not cached, flush only while ready
`timescale 1ns/1ns

module tlb
    import mmu_pkg::*;
#(
    parameter bit instr_side = 1'b0
)(
    input  logic    clk_i,
    input  logic    rst_n_i,

    // Lookup request and response
    input  logic    req_valid_i,
    input  vpn_t    req_vpn_i,
    output logic    ready_o,
    output logic    resp_valid_o,
    output ppn_t    resp_ppn_o,
    output logic    resp_fault_o,

    // Translation control
    input  priv_t   priv_i,
    input  logic    vm_enable_i,
    input  logic    flush_i,

    // Walker side
    output logic    walk_valid_o,
    output vpn_t    walk_vpn_o,
    input  logic    walk_done_i,
    input  ppn_t    walk_ppn_i,
    input  logic    walk_leaf_ok_i,
    input  logic    walk_x_i,
    input  logic    walk_r_i,
    input  logic    walk_u_i
);

    tlb_state_t state_q;

    // Entry storage
    logic [tlb_entries-1:0]         entry_valid_q;
    vpn_t                           entry_vpn_q [tlb_entries];
    ppn_t                           entry_ppn_q [tlb_entries];
    logic [tlb_entries-1:0]         entry_x_q;
    logic [tlb_entries-1:0]         entry_r_q;
    logic [tlb_entries-1:0]         entry_u_q;
    logic [$clog2(tlb_entries)-1:0] rr_ptr_q;

    // Request and result payload
    vpn_t   vpn_q;
    priv_t  priv_q;
    ppn_t   resp_ppn_q;
    logic   resp_fault_q;

    // Lookup results
    logic   hit;
    ppn_t   hit_ppn;
    logic   hit_x;
    logic   hit_r;
    logic   hit_u;
    logic   walk_fault;
    logic   fill;

    // Side permission plus user/supervisor match
    function automatic logic perm_fault(input logic leaf_ok, input logic x, input logic r,
                                        input logic u, input priv_t priv);
        logic side_ok;
        logic u_ok;
        side_ok = instr_side ? x : r;
        u_ok    = (priv == priv_user) ? u : !u;
        return !leaf_ok || !side_ok || !u_ok;
    endfunction

    // ------------------------------------------------------------------
    // Associative lookup
    // ------------------------------------------------------------------
    always_comb begin
        hit     = 1'b0;
        hit_ppn = '0;
        hit_x   = 1'b0;
        hit_r   = 1'b0;
        hit_u   = 1'b0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (entry_valid_q[i] && entry_vpn_q[i] == req_vpn_i) begin
                hit     = 1'b1;
                hit_ppn = entry_ppn_q[i];
                hit_x   = entry_x_q[i];
                hit_r   = entry_r_q[i];
                hit_u   = entry_u_q[i];
            end
        end
    end

    assign walk_fault = perm_fault(walk_leaf_ok_i, walk_x_i, walk_r_i, walk_u_i, priv_q);

    // Only permitted walk results go into the array
    assign fill = (state_q == tlb_walk) && walk_done_i && !walk_fault;

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= tlb_idle;
            entry_valid_q <= '0;
            rr_ptr_q      <= '0;
        end else begin
            case (state_q)
                tlb_idle: begin
                    if (flush_i) begin
                        entry_valid_q <= '0;
                    end
                    if (req_valid_i) begin
                        if (!vm_enable_i || hit) begin
                            state_q <= tlb_respond;
                        end else begin
                            state_q <= tlb_walk;
                        end
                    end
                end
                tlb_walk: begin
                    if (walk_done_i) begin
                        state_q <= tlb_respond;
                    end
                    if (fill) begin
                        entry_valid_q[rr_ptr_q] <= 1'b1;
                        if (rr_ptr_q == tlb_entries - 1) begin
                            rr_ptr_q <= '0;
                        end else begin
                            rr_ptr_q <= rr_ptr_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= tlb_idle;
                end
            endcase
        end
    end

    // Payload and entry contents
    always_ff @(posedge clk_i) begin
        if (state_q == tlb_idle && req_valid_i) begin
            vpn_q  <= req_vpn_i;
            priv_q <= priv_i;
            if (!vm_enable_i) begin
                // Bare mode, PPN is the zero-extended VPN
                resp_ppn_q   <= {{(ppn_w - vpn_w){1'b0}}, req_vpn_i};
                resp_fault_q <= 1'b0;
            end else begin
                resp_ppn_q   <= hit_ppn;
                resp_fault_q <= perm_fault(1'b1, hit_x, hit_r, hit_u, priv_i);
            end
        end
        if (state_q == tlb_walk && walk_done_i) begin
            resp_ppn_q   <= walk_ppn_i;
            resp_fault_q <= walk_fault;
        end
        if (fill) begin
            entry_vpn_q[rr_ptr_q] <= vpn_q;
            entry_ppn_q[rr_ptr_q] <= walk_ppn_i;
            entry_x_q[rr_ptr_q]   <= walk_x_i;
            entry_r_q[rr_ptr_q]   <= walk_r_i;
            entry_u_q[rr_ptr_q]   <= walk_u_i;
        end
    end

    assign ready_o      = (state_q == tlb_idle);
    assign resp_valid_o = (state_q == tlb_respond);
    assign resp_ppn_o   = resp_ppn_q;
    assign resp_fault_o = resp_fault_q;

    // Walk request held from miss until done
    assign walk_valid_o = (state_q == tlb_walk);
    assign walk_vpn_o   = vpn_q;

endmodule

//--- hdl/mmu_pkg.sv
// Sv39-style widths and encodings only; no ASIDs, no A/D update, 3 levels and 4 TLB entries fixed
package mmu_pkg;

    // ------------------------------------------------------------------
    // Address widths
    // ------------------------------------------------------------------
    localparam int vpn_w       = 27;
    localparam int ppn_w       = 44;
    localparam int pa_w        = 56;
    localparam int page_off_w  = 12;

    // Walk geometry
    localparam int levels      = 3;
    localparam int vpn_seg_w   = 9;

    // Fully associative, round-robin refill
    localparam int tlb_entries = 4;

    // ------------------------------------------------------------------
    // PTE layout
    // ------------------------------------------------------------------
    localparam int pte_v_bit   = 0;
    localparam int pte_r_bit   = 1;
    localparam int pte_w_bit   = 2;
    localparam int pte_x_bit   = 3;
    localparam int pte_u_bit   = 4;
    localparam int pte_ppn_lsb = 10;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef logic [vpn_w-1:0]           vpn_t;
    typedef logic [ppn_w-1:0]           ppn_t;
    typedef logic [pa_w-1:0]            paddr_t;
    typedef logic [63:0]                pte_t;
    typedef logic [$clog2(levels)-1:0]  level_t;

    // RISC-V privilege encoding, machine mode not modelled
    typedef enum logic [1:0] {
        priv_user       = 2'b00,
        priv_supervisor = 2'b01
    } priv_t;

    typedef enum logic [1:0] {
        tlb_idle,
        tlb_respond,
        tlb_walk
    } tlb_state_t;

    typedef enum logic [1:0] {
        ptw_idle,
        ptw_mem_req,
        ptw_mem_wait,
        ptw_done
    } ptw_state_t;

endpackage
